/* source/mxint_pkg.sv */
package mxint_pkg;

  // Input element format
  localparam int MAN_W = 8;
  localparam int EXP_W = 4;

  // Block geometry, one exponent per 2x2 block
  localparam int PAR    = 2;
  localparam int LANES  = PAR * PAR;
  localparam int TENSOR = 4;
  localparam int DEPTH  = TENSOR / PAR;

  // Datapath widths
  localparam int DOT_W     = 17;
  localparam int SUM_EXP_W = 6;
  localparam int ACC_W     = 20;

  // Output element format
  localparam int OUT_MAN_W = 8;
  localparam int OUT_EXP_W = 6;

  // Signed exponent difference, one bit wider than the exponent
  localparam int DIFF_W  = SUM_EXP_W + 1;
  // Cast shift covers 0..ACC_W
  localparam int SHIFT_W = $clog2(ACC_W + 1);

  typedef struct packed {
    logic [LANES-1:0][MAN_W-1:0] man;
    logic [EXP_W-1:0]            exp;
  } mx_block_t;

  // One lane per output column
  typedef struct packed {
    logic [PAR-1:0][MAN_W-1:0] man;
    logic [EXP_W-1:0]          exp;
  } mx_bias_t;

  typedef struct packed {
    logic [LANES-1:0][DOT_W-1:0] man;
    logic [SUM_EXP_W-1:0]        exp;
  } mx_dot_t;

  typedef struct packed {
    logic [LANES-1:0][ACC_W-1:0] man;
    logic [SUM_EXP_W-1:0]        exp;
  } mx_wide_t;

  typedef struct packed {
    logic [LANES-1:0][OUT_MAN_W-1:0] man;
    logic [OUT_EXP_W-1:0]            exp;
  } mx_out_t;

endpackage

/* source/mxint_circular.sv */
`timescale 1ns/1ns

module mxint_circular #(
  parameter int WIDTH_P  = 8,
  parameter int DEPTH_P  = 2,
  parameter int REPEAT_P = 2
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic [WIDTH_P-1:0] in_data,
  input  logic               in_valid,
  output logic               in_ready,
  output logic [WIDTH_P-1:0] out_data,
  output logic               out_valid,
  input  logic               out_ready
);
  localparam int PTR_W = $clog2(DEPTH_P);
  localparam int REP_W = $clog2(REPEAT_P);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH_P - 1);
  localparam logic [REP_W-1:0] LAST_REP = REP_W'(REPEAT_P - 1);

  logic [WIDTH_P-1:0] mem [DEPTH_P];
  logic [PTR_W-1:0]   fill_cnt;
  logic [PTR_W-1:0]   rd_ptr;
  logic [REP_W-1:0]   rep_cnt;
  logic               replaying;
  logic               load;
  logic               take;

  // Load and replay never overlap
  assign in_ready  = !replaying;
  assign out_valid = replaying;
  assign out_data  = mem[rd_ptr];

  assign load = in_valid && in_ready;
  assign take = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (load) begin
      mem[fill_cnt] <= in_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fill_cnt  <= '0;
      rd_ptr    <= '0;
      rep_cnt   <= '0;
      replaying <= 1'b0;
    end else begin
      if (load) begin
        if (fill_cnt == LAST_PTR) begin
          fill_cnt  <= '0;
          replaying <= 1'b1;
        end else begin
          fill_cnt <= fill_cnt + 1'b1;
        end
      end
      if (take) begin
        if (rd_ptr == LAST_PTR) begin
          rd_ptr <= '0;
          // Last pass over the tile frees the buffer for the next load
          if (rep_cnt == LAST_REP) begin
            rep_cnt   <= '0;
            replaying <= 1'b0;
          end else begin
            rep_cnt <= rep_cnt + 1'b1;
          end
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

endmodule

/* source/mxint_dot_product.sv */
`timescale 1ns/1ns

module mxint_dot_product (
  input  logic                clk,
  input  logic                arst_n,
  input  mxint_pkg::mx_block_t x,
  input  logic                x_valid,
  output logic                x_ready,
  input  mxint_pkg::mx_block_t w,
  input  logic                w_valid,
  output logic                w_ready,
  output mxint_pkg::mx_dot_t   dot,
  output logic                dot_valid,
  input  logic                dot_ready
);
  import mxint_pkg::*;

  mx_dot_t dot_next;
  logic    out_free;
  logic    load;

  // Output register takes new data when empty or draining
  assign out_free = !dot_valid || dot_ready;

  // Both operands are taken on the same edge
  assign x_ready = w_valid && out_free;
  assign w_ready = x_valid && out_free;
  assign load    = x_valid && w_valid && out_free;

  always_comb begin
    logic signed [DOT_W-1:0] lane_sum;
    for (int i = 0; i < PAR; i++) begin
      for (int j = 0; j < PAR; j++) begin
        lane_sum = '0;
        // Row i of x against output column j of w
        for (int k = 0; k < PAR; k++) begin
          lane_sum = lane_sum + $signed(x.man[i*PAR+k]) * $signed(w.man[j*PAR+k]);
        end
        dot_next.man[i*PAR+j] = lane_sum;
      end
    end
    dot_next.exp = SUM_EXP_W'($signed(x.exp)) + SUM_EXP_W'($signed(w.exp));
  end

  always_ff @(posedge clk) begin
    if (load) begin
      dot <= dot_next;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dot_valid <= 1'b0;
    end else if (out_free) begin
      dot_valid <= load;
    end
  end

endmodule

/* source/mxint_accumulator.sv */
`timescale 1ns/1ns

module mxint_accumulator (
  input  logic              clk,
  input  logic              arst_n,
  input  mxint_pkg::mx_dot_t dot,
  input  logic              dot_valid,
  output logic              dot_ready,
  output mxint_pkg::mx_wide_t acc,
  output logic              acc_valid,
  input  logic              acc_ready
);
  import mxint_pkg::*;

  mx_wide_t                 acc_next;
  logic [$clog2(DEPTH)-1:0] part_cnt;
  logic                     first;
  logic                     part_larger;
  logic signed [DIFF_W-1:0] exp_diff;
  logic [DIFF_W-1:0]        shamt;
  logic                     take_in;

  // Stall input while the finished sum waits downstream
  assign dot_ready = !acc_valid;
  assign take_in   = dot_valid && dot_ready;
  assign first     = (part_cnt == '0);

  // Larger-exponent rule, the smaller side is shifted right
  assign exp_diff    = $signed({dot.exp[SUM_EXP_W-1], dot.exp})
                     - $signed({acc.exp[SUM_EXP_W-1], acc.exp});
  assign part_larger = exp_diff > 0;
  assign shamt       = part_larger ? exp_diff : -exp_diff;

  always_comb begin
    logic signed [ACC_W-1:0] part;
    for (int l = 0; l < LANES; l++) begin
      part = ACC_W'($signed(dot.man[l]));
      if (first) begin
        acc_next.man[l] = part;
      end else if (part_larger) begin
        acc_next.man[l] = ($signed(acc.man[l]) >>> shamt) + part;
      end else begin
        acc_next.man[l] = $signed(acc.man[l]) + (part >>> shamt);
      end
    end
    if (first || part_larger) begin
      acc_next.exp = dot.exp;
    end else begin
      acc_next.exp = acc.exp;
    end
  end

  always_ff @(posedge clk) begin
    if (take_in) begin
      acc <= acc_next;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      part_cnt  <= '0;
      acc_valid <= 1'b0;
    end else begin
      if (acc_valid && acc_ready) begin
        acc_valid <= 1'b0;
      end
      if (take_in) begin
        if (part_cnt == DEPTH - 1) begin
          part_cnt  <= '0;
          acc_valid <= 1'b1;
        end else begin
          part_cnt <= part_cnt + 1'b1;
        end
      end
    end
  end

endmodule

/* source/mxint_bias_add.sv */
`timescale 1ns/1ns

module mxint_bias_add (
  input  mxint_pkg::mx_wide_t acc,
  input  logic               acc_valid,
  output logic               acc_ready,
  input  mxint_pkg::mx_bias_t bias,
  input  logic               bias_valid,
  output logic               bias_ready,
  output mxint_pkg::mx_wide_t sum,
  output logic               sum_valid,
  input  logic               sum_ready
);
  import mxint_pkg::*;

  logic signed [DIFF_W-1:0] exp_diff;
  logic [DIFF_W-1:0]        shamt;
  logic                     bias_larger;

  // Two-input join, nothing registered here
  assign sum_valid  = acc_valid && bias_valid;
  assign acc_ready  = sum_ready && bias_valid;
  assign bias_ready = sum_ready && acc_valid;

  assign exp_diff    = DIFF_W'($signed(bias.exp))
                     - $signed({acc.exp[SUM_EXP_W-1], acc.exp});
  assign bias_larger = exp_diff > 0;
  assign shamt       = bias_larger ? exp_diff : -exp_diff;

  always_comb begin
    logic signed [ACC_W-1:0] b_ext;
    for (int i = 0; i < PAR; i++) begin
      for (int j = 0; j < PAR; j++) begin
        // Bias lane j serves output column j of every row
        b_ext = ACC_W'($signed(bias.man[j]));
        if (bias_larger) begin
          sum.man[i*PAR+j] = ($signed(acc.man[i*PAR+j]) >>> shamt) + b_ext;
        end else begin
          sum.man[i*PAR+j] = $signed(acc.man[i*PAR+j]) + (b_ext >>> shamt);
        end
      end
    end
    if (bias_larger) begin
      sum.exp = SUM_EXP_W'($signed(bias.exp));
    end else begin
      sum.exp = acc.exp;
    end
  end

endmodule

/* source/mxint_cast.sv */
`timescale 1ns/1ns

module mxint_cast (
  input  logic               clk,
  input  logic               arst_n,
  input  mxint_pkg::mx_wide_t sum,
  input  logic               sum_valid,
  output logic               sum_ready,
  output mxint_pkg::mx_out_t  y,
  output logic               y_valid,
  input  logic               y_ready
);
  import mxint_pkg::*;

  mx_out_t            y_next;
  logic [SHIFT_W-1:0] shift;
  logic               load;

  assign sum_ready = !y_valid || y_ready;
  assign load      = sum_valid && sum_ready;

  // Smallest common shift that brings every lane into OUT_MAN_W bits
  always_comb begin
    logic signed [ACC_W-1:0] hi;
    logic                    all_fit;
    shift = SHIFT_W'(ACC_W);
    // Scan downward so the last hit is the smallest shift
    for (int s = ACC_W; s >= 0; s--) begin
      all_fit = 1'b1;
      for (int l = 0; l < LANES; l++) begin
        // A lane fits when the bits above its new sign bit are all sign
        hi = $signed(sum.man[l]) >>> (s + OUT_MAN_W - 1);
        if (!((hi == '0) || (&hi))) begin
          all_fit = 1'b0;
        end
      end
      if (all_fit) begin
        shift = SHIFT_W'(s);
      end
    end
  end

  always_comb begin
    logic signed [ACC_W-1:0] shifted;
    for (int l = 0; l < LANES; l++) begin
      shifted       = $signed(sum.man[l]) >>> shift;
      y_next.man[l] = shifted[OUT_MAN_W-1:0];
    end
    // Exponent grows by the shift so the value is kept
    y_next.exp = OUT_EXP_W'($signed(sum.exp)) + OUT_EXP_W'(shift);
  end

  always_ff @(posedge clk) begin
    if (load) begin
      y <= y_next;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      y_valid <= 1'b0;
    end else if (sum_ready) begin
      y_valid <= load;
    end
  end

endmodule

/* source/mxint_linear.sv */
`timescale 1ns/1ns

module mxint_linear (
  input  logic                clk,
  input  logic                arst_n,
  input  mxint_pkg::mx_block_t x_blk,
  input  logic                x_valid,
  output logic                x_ready,
  input  mxint_pkg::mx_block_t w_blk,
  input  logic                w_valid,
  output logic                w_ready,
  input  mxint_pkg::mx_bias_t  b_blk,
  input  logic                b_valid,
  output logic                b_ready,
  output mxint_pkg::mx_out_t   y_blk,
  output logic                y_valid,
  input  logic                y_ready
);
  import mxint_pkg::*;

  mx_block_t x_rep;
  logic      x_rep_valid;
  logic      x_rep_ready;

  mx_block_t w_rep;
  logic      w_rep_valid;
  logic      w_rep_ready;

  mx_bias_t  b_rep;
  logic      b_rep_valid;
  logic      b_rep_ready;

  mx_dot_t   dot;
  logic      dot_valid;
  logic      dot_ready;

  mx_wide_t  acc;
  logic      acc_valid;
  logic      acc_ready;

  mx_wide_t  sum;
  logic      sum_valid;
  logic      sum_ready;

  // One row group of x, replayed for each output column block
  mxint_circular #(
    .WIDTH_P  ($bits(mx_block_t)),
    .DEPTH_P  (DEPTH),
    .REPEAT_P (DEPTH)
  ) data_buffer (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (x_blk),
    .in_valid  (x_valid),
    .in_ready  (x_ready),
    .out_data  (x_rep),
    .out_valid (x_rep_valid),
    .out_ready (x_rep_ready)
  );

  // Whole weight matrix, replayed for each row group
  mxint_circular #(
    .WIDTH_P  ($bits(mx_block_t)),
    .DEPTH_P  (DEPTH * DEPTH),
    .REPEAT_P (DEPTH)
  ) weight_buffer (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (w_blk),
    .in_valid  (w_valid),
    .in_ready  (w_ready),
    .out_data  (w_rep),
    .out_valid (w_rep_valid),
    .out_ready (w_rep_ready)
  );

  mxint_circular #(
    .WIDTH_P  ($bits(mx_bias_t)),
    .DEPTH_P  (DEPTH),
    .REPEAT_P (DEPTH)
  ) bias_buffer (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (b_blk),
    .in_valid  (b_valid),
    .in_ready  (b_ready),
    .out_data  (b_rep),
    .out_valid (b_rep_valid),
    .out_ready (b_rep_ready)
  );

  mxint_dot_product dot_product (
    .clk       (clk),
    .arst_n    (arst_n),
    .x         (x_rep),
    .x_valid   (x_rep_valid),
    .x_ready   (x_rep_ready),
    .w         (w_rep),
    .w_valid   (w_rep_valid),
    .w_ready   (w_rep_ready),
    .dot       (dot),
    .dot_valid (dot_valid),
    .dot_ready (dot_ready)
  );

  mxint_accumulator accumulator (
    .clk       (clk),
    .arst_n    (arst_n),
    .dot       (dot),
    .dot_valid (dot_valid),
    .dot_ready (dot_ready),
    .acc       (acc),
    .acc_valid (acc_valid),
    .acc_ready (acc_ready)
  );

  mxint_bias_add bias_add (
    .acc        (acc),
    .acc_valid  (acc_valid),
    .acc_ready  (acc_ready),
    .bias       (b_rep),
    .bias_valid (b_rep_valid),
    .bias_ready (b_rep_ready),
    .sum        (sum),
    .sum_valid  (sum_valid),
    .sum_ready  (sum_ready)
  );

  mxint_cast cast (
    .clk       (clk),
    .arst_n    (arst_n),
    .sum       (sum),
    .sum_valid (sum_valid),
    .sum_ready (sum_ready),
    .y         (y_blk),
    .y_valid   (y_valid),
    .y_ready   (y_ready)
  );

endmodule

/* test/mxint_linear_asserts.sv */
`timescale 1ns/1ns

module mxint_linear_asserts (
  input logic                 clk,
  input logic                 arst_n,
  input mxint_pkg::mx_block_t x_blk,
  input logic                 x_valid,
  input logic                 x_ready,
  input logic                 x_rep_valid,
  input logic                 x_rep_ready,
  input mxint_pkg::mx_block_t w_blk,
  input logic                 w_valid,
  input logic                 w_ready,
  input mxint_pkg::mx_bias_t  b_blk,
  input logic                 b_valid,
  input logic                 b_ready,
  input mxint_pkg::mx_out_t   y_blk,
  input logic                 y_valid,
  input logic                 y_ready
);
  import mxint_pkg::*;

  int   x_loads;
  int   x_takes;
  logic x_owed;

  // Blocks taken into and replayed out of the data buffer
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      x_loads <= 0;
      x_takes <= 0;
    end else begin
      if (x_valid && x_ready) begin
        x_loads <= x_loads + 1;
      end
      if (x_rep_valid && x_rep_ready) begin
        x_takes <= x_takes + 1;
      end
    end
  end

  // A whole row group is loaded and its replays are not all taken yet
  assign x_owed = (x_loads % DEPTH == 0) && (x_loads * DEPTH > x_takes);

  // Stalled streams keep valid and data
  x_hold: assert property (@(posedge clk) disable iff (!arst_n)
    x_valid && !x_ready |=> x_valid && $stable(x_blk))
    else $error("x stream changed while stalled");

  w_hold: assert property (@(posedge clk) disable iff (!arst_n)
    w_valid && !w_ready |=> w_valid && $stable(w_blk))
    else $error("w stream changed while stalled");

  b_hold: assert property (@(posedge clk) disable iff (!arst_n)
    b_valid && !b_ready |=> b_valid && $stable(b_blk))
    else $error("bias stream changed while stalled");

  y_hold: assert property (@(posedge clk) disable iff (!arst_n)
    y_valid && !y_ready |=> y_valid && $stable(y_blk))
    else $error("y stream changed while stalled");

  y_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !y_valid)
    else $error("y_valid high during reset");

  // Data buffer never loads during a replay
  x_no_load_in_replay: assert property (@(posedge clk) disable iff (!arst_n)
    x_owed |-> !x_ready)
    else $error("x_ready high while the data buffer replays");

endmodule

bind mxint_linear mxint_linear_asserts asserts0 (
  .clk         (clk),
  .arst_n      (arst_n),
  .x_blk       (x_blk),
  .x_valid     (x_valid),
  .x_ready     (x_ready),
  .x_rep_valid (x_rep_valid),
  .x_rep_ready (x_rep_ready),
  .w_blk       (w_blk),
  .w_valid     (w_valid),
  .w_ready     (w_ready),
  .b_blk       (b_blk),
  .b_valid     (b_valid),
  .b_ready     (b_ready),
  .y_blk       (y_blk),
  .y_valid     (y_valid),
  .y_ready     (y_ready)
);

/* test/tb_mxint_linear.sv */
`timescale 1ns/1ns

module tb_mxint_linear;
  import mxint_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int SEED         = 75267;
  localparam int DRAIN_CYCLES = 20;
  localparam int OUT_MAX      = 2 ** (OUT_MAN_W - 1) - 1;
  localparam int OUT_MIN      = -(2 ** (OUT_MAN_W - 1));
  localparam int BLOCKS_PER_M = DEPTH * DEPTH;

  // Matrices per test
  localparam int N_SINGLE   = 1;
  localparam int N_STREAM   = 20;
  localparam int N_BACKPR   = 20;
  localparam int N_ALIGN    = 8;
  localparam int N_CAST     = 4;
  localparam int N_MATRICES = N_SINGLE + N_STREAM + N_BACKPR + N_ALIGN + N_CAST;
  localparam int WATCHDOG_NS =
    (N_MATRICES * 200 + RESET_CYCLES + 5 * DRAIN_CYCLES) * CLK_PERIOD;

  logic      clk     = 1'b0;
  logic      arst_n  = 1'b1;
  mx_block_t x_blk   = '0;
  logic      x_valid = 1'b0;
  logic      x_ready;
  mx_block_t w_blk   = '0;
  logic      w_valid = 1'b0;
  logic      w_ready;
  mx_bias_t  b_blk   = '0;
  logic      b_valid = 1'b0;
  logic      b_ready;
  mx_out_t   y_blk;
  logic      y_valid;
  logic      y_ready = 1'b0;

  mx_block_t x_q [$];
  mx_block_t w_q [$];
  mx_bias_t  b_q [$];
  mx_out_t   exp_q [$];

  int    valid_pct = 100;
  int    ready_pct = 100;
  int    errors = 0;
  int    out_cnt = 0;
  int    tests_passed = 0;
  int    tests_failed = 0;
  int    test_err0;
  int    test_out0;
  string cur_test;

  mxint_linear dut0 (
    .clk     (clk),
    .arst_n  (arst_n),
    .x_blk   (x_blk),
    .x_valid (x_valid),
    .x_ready (x_ready),
    .w_blk   (w_blk),
    .w_valid (w_valid),
    .w_ready (w_ready),
    .b_blk   (b_blk),
    .b_valid (b_valid),
    .b_ready (b_ready),
    .y_blk   (y_blk),
    .y_valid (y_valid),
    .y_ready (y_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($urandom % 32'(hi - lo + 1));
  endfunction

  function automatic bit chance(input int pct);
    return ($urandom % 100) < 32'(pct);
  endfunction

  // Smallest right shift that brings all lanes into the output mantissa range
  function automatic mx_out_t cast_block(input int man [LANES], input int e);
    mx_out_t o;
    int      s;
    int      v;
    bit      fits;
    for (s = 0; s < ACC_W; s++) begin
      fits = 1'b1;
      for (int l = 0; l < LANES; l++) begin
        v = man[l] >>> s;
        if (v > OUT_MAX || v < OUT_MIN) begin
          fits = 1'b0;
        end
      end
      if (fits) begin
        break;
      end
    end
    for (int l = 0; l < LANES; l++) begin
      o.man[l] = OUT_MAN_W'(man[l] >>> s);
    end
    o.exp = OUT_EXP_W'(e + s);
    return o;
  endfunction

  // Reference linear layer, output blocks pushed in r then j order
  task automatic model_matrix(input mx_block_t xb [4], input mx_block_t wb [4],
                              input mx_bias_t bb [2]);
    int acc [LANES];
    int part [LANES];
    int acc_exp;
    int part_exp;
    int bias_exp;
    int bias_man;
    int l;
    for (int r = 0; r < DEPTH; r++) begin
      for (int j = 0; j < DEPTH; j++) begin
        for (int c = 0; c < DEPTH; c++) begin
          part_exp = int'($signed(xb[r*DEPTH+c].exp)) + int'($signed(wb[j*DEPTH+c].exp));
          for (int i = 0; i < PAR; i++) begin
            for (int jj = 0; jj < PAR; jj++) begin
              l = i * PAR + jj;
              part[l] = 0;
              for (int k = 0; k < PAR; k++) begin
                part[l] += int'($signed(xb[r*DEPTH+c].man[i*PAR+k]))
                         * int'($signed(wb[j*DEPTH+c].man[jj*PAR+k]));
              end
            end
          end
          for (int n = 0; n < LANES; n++) begin
            if (c == 0) begin
              acc[n] = part[n];
            end else if (part_exp > acc_exp) begin
              acc[n] = (acc[n] >>> (part_exp - acc_exp)) + part[n];
            end else begin
              acc[n] = acc[n] + (part[n] >>> (acc_exp - part_exp));
            end
          end
          if (c == 0 || part_exp > acc_exp) begin
            acc_exp = part_exp;
          end
        end
        bias_exp = int'($signed(bb[j].exp));
        for (int i = 0; i < PAR; i++) begin
          for (int jj = 0; jj < PAR; jj++) begin
            l = i * PAR + jj;
            bias_man = int'($signed(bb[j].man[jj]));
            if (bias_exp > acc_exp) begin
              acc[l] = (acc[l] >>> (bias_exp - acc_exp)) + bias_man;
            end else begin
              acc[l] = acc[l] + (bias_man >>> (acc_exp - bias_exp));
            end
          end
        end
        if (bias_exp > acc_exp) begin
          acc_exp = bias_exp;
        end
        exp_q.push_back(cast_block(acc, acc_exp));
      end
    end
  endtask

  // One matrix of x, w and bias in host order
  task automatic gen_matrix(input int man_lo, input int man_hi,
                            input int exp_lo, input int exp_hi);
    mx_block_t xb [4];
    mx_block_t wb [4];
    mx_bias_t  bb [2];
    for (int n = 0; n < 4; n++) begin
      for (int l = 0; l < LANES; l++) begin
        xb[n].man[l] = MAN_W'(rand_range(man_lo, man_hi));
        wb[n].man[l] = MAN_W'(rand_range(man_lo, man_hi));
      end
      xb[n].exp = EXP_W'(rand_range(exp_lo, exp_hi));
      wb[n].exp = EXP_W'(rand_range(exp_lo, exp_hi));
      x_q.push_back(xb[n]);
      w_q.push_back(wb[n]);
    end
    for (int n = 0; n < 2; n++) begin
      for (int l = 0; l < PAR; l++) begin
        bb[n].man[l] = MAN_W'(rand_range(man_lo, man_hi));
      end
      bb[n].exp = EXP_W'(rand_range(exp_lo, exp_hi));
      b_q.push_back(bb[n]);
    end
    model_matrix(xb, wb, bb);
  endtask

  task automatic start_test(input string name, input int vpct, input int rpct);
    @(negedge clk);
    cur_test  = name;
    valid_pct = vpct;
    ready_pct = rpct;
    test_err0 = errors;
    test_out0 = out_cnt;
  endtask

  task automatic end_test(input int n_mat);
    while (x_q.size() != 0 || w_q.size() != 0 || b_q.size() != 0 || exp_q.size() != 0) begin
      @(posedge clk);
    end
    // Extra blocks would show up here
    repeat (DRAIN_CYCLES) @(posedge clk);
    if (out_cnt - test_out0 != n_mat * BLOCKS_PER_M) begin
      $display("%s: saw %0d output blocks where %0d were expected",
               cur_test, out_cnt - test_out0, n_mat * BLOCKS_PER_M);
      errors++;
    end
    if (errors == test_err0) begin
      $display("%s: passed, %0d blocks checked", cur_test, n_mat * BLOCKS_PER_M);
      tests_passed++;
    end else begin
      $display("%s: failed with %0d errors", cur_test, errors - test_err0);
      tests_failed++;
    end
  endtask

  // Producers hold valid and data until the transfer
  always @(posedge clk) begin
    if (x_valid && x_ready) begin
      void'(x_q.pop_front());
    end
    if (w_valid && w_ready) begin
      void'(w_q.pop_front());
    end
    if (b_valid && b_ready) begin
      void'(b_q.pop_front());
    end
    if (!arst_n) begin
      x_valid <= 1'b0;
      w_valid <= 1'b0;
      b_valid <= 1'b0;
    end else begin
      if (!x_valid || x_ready) begin
        x_valid <= (x_q.size() > 0) && chance(valid_pct);
        if (x_q.size() > 0) begin
          x_blk <= x_q[0];
        end
      end
      if (!w_valid || w_ready) begin
        w_valid <= (w_q.size() > 0) && chance(valid_pct);
        if (w_q.size() > 0) begin
          w_blk <= w_q[0];
        end
      end
      if (!b_valid || b_ready) begin
        b_valid <= (b_q.size() > 0) && chance(valid_pct);
        if (b_q.size() > 0) begin
          b_blk <= b_q[0];
        end
      end
    end
  end

  // Consumer and scoreboard
  always @(posedge clk) begin
    mx_out_t exp_blk;
    if (arst_n && y_valid && y_ready) begin
      out_cnt++;
      if (exp_q.size() == 0) begin
        $display("Output block at %0t ns arrived with no block left to compare", $time);
        errors++;
      end else begin
        exp_blk = exp_q.pop_front();
        for (int l = 0; l < LANES; l++) begin
          if (y_blk.man[l] !== exp_blk.man[l]) begin
            $display("FAILED %0t ns y_blk.man[%0d] expected %0d got %0d", $time, l,
                     $signed(exp_blk.man[l]), $signed(y_blk.man[l]));
            errors++;
          end
        end
        if (y_blk.exp !== exp_blk.exp) begin
          $display("FAILED %0t ns y_blk.exp expected %0d got %0d", $time,
                   $signed(exp_blk.exp), $signed(y_blk.exp));
          errors++;
        end
      end
    end
    if (!arst_n) begin
      y_ready <= 1'b0;
    end else begin
      y_ready <= chance(ready_pct);
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Run timed out after %0d ns with blocks still outstanding", WATCHDOG_NS);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    // Reset goes low before the first clock edge
    #1;
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;

    start_test("single_matrix", 100, 100);
    gen_matrix(-128, 127, -4, 3);
    end_test(N_SINGLE);

    start_test("back_to_back", 100, 100);
    repeat (N_STREAM) gen_matrix(-128, 127, -4, 3);
    end_test(N_STREAM);

    start_test("back_pressure", 70, 50);
    repeat (N_BACKPR) gen_matrix(-128, 127, -4, 3);
    end_test(N_BACKPR);

    start_test("exponent_alignment", 80, 70);
    repeat (N_ALIGN) gen_matrix(-128, 127, -8, 7);
    end_test(N_ALIGN);

    // Zero, both extremes, then results that already fit
    start_test("cast_edges", 100, 60);
    gen_matrix(0, 0, -4, 3);
    gen_matrix(-128, -128, -4, 3);
    gen_matrix(127, 127, -4, 3);
    gen_matrix(-2, 2, -4, 3);
    end_test(N_CAST);

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* mxint_linear.f */
source/mxint_pkg.sv
source/mxint_circular.sv
source/mxint_dot_product.sv
source/mxint_accumulator.sv
source/mxint_bias_add.sv
source/mxint_cast.sv
source/mxint_linear.sv
test/mxint_linear_asserts.sv
test/tb_mxint_linear.sv

/* Makefile */
TOP := tb_mxint_linear

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f mxint_linear.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f mxint_linear.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qxF "=== PASS ==="

clean:
	rm -rf obj_dir
